//--- common/sd_host_pkg.sv
package sd_host_pkg;

    localparam int APB_ADDR_W  = 8;
    localparam int DATA_W      = 32;
    localparam int DIV_W       = 8;
    localparam int CMD_FRAME_W = 48;
    localparam int CMD_INDEX_W = 6;
    localparam int CRC7_W      = 7;

    // x^7 + x^3 + 1
    localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

    // Start bit 0, direction bit 1 (host to card)
    localparam logic [1:0] FRAME_PREFIX_HOST = 2'b01;

    // Writable bits of COMMAND
    localparam logic [DATA_W-1:0] CMD_REG_MASK = 32'h0000_3f1b;

    typedef enum logic [APB_ADDR_W-1:0] {
        ARGUMENT      = 8'h00,
        COMMAND       = 8'h04,
        RESPONSE      = 8'h08,
        CLOCK_DIV     = 8'h0c,
        INT_STATUS    = 8'h10,
        INT_ENABLE    = 8'h14,
        PRESENT_STATE = 8'h18
    } reg_addr_e;

    // Anything but RESP_NONE is received as a 48-bit response
    typedef enum logic [1:0] {
        RESP_NONE    = 2'd0,
        RESP_136     = 2'd1,
        RESP_48      = 2'd2,
        RESP_48_BUSY = 2'd3
    } resp_type_e;

    // COMMAND register layout
    typedef struct packed {
        logic [17:0]            rsvd_hi;
        logic [CMD_INDEX_W-1:0] index;
        logic [2:0]             rsvd_mid;
        logic                   index_check;
        logic                   crc_check;
        logic                   rsvd_lo;
        resp_type_e             resp_type;
    } cmd_reg_t;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [DATA_W-1:0]      argument;
        resp_type_e             resp_type;
        logic                   crc_check;
        logic                   index_check;
    } cmd_req_t;

    typedef struct packed {
        logic [1:0]             prefix;
        logic [CMD_INDEX_W-1:0] index;
        logic [DATA_W-1:0]      argument;
    } cmd_frame_t;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [DATA_W-1:0]      argument;
        logic                   crc_ok;
        logic                   timeout;
        logic                   received;
    } cmd_rsp_t;

    // cmd_complete is bit 0
    typedef struct packed {
        logic cmd_index_err;
        logic cmd_crc_err;
        logic cmd_timeout;
        logic cmd_complete;
    } int_status_t;

    typedef struct packed {
        logic rise;
        logic fall;
    } sd_strobe_t;

endpackage

//--- src/sd_regs.sv
`timescale 1ns/1ps

module sd_regs (
    input  logic                               pclk_i,
    input  logic                               reset_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [sd_host_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [sd_host_pkg::DATA_W-1:0]     pwdata_i,
    output logic [sd_host_pkg::DATA_W-1:0]     prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    input  logic                               cmd_busy_i,
    input  logic                               cmd_done_i,
    input  sd_host_pkg::int_status_t           cmd_status_i,
    input  logic [sd_host_pkg::DATA_W-1:0]     cmd_resp_arg_i,
    output sd_host_pkg::cmd_req_t              cmd_req_o,
    output logic                               cmd_start_o,
    output logic [sd_host_pkg::DIV_W-1:0]      divisor_o,
    output logic                               interrupt_o
);

    import sd_host_pkg::*;

    logic [DATA_W-1:0] argument_q;
    cmd_reg_t          cmd_q;
    logic [DATA_W-1:0] response_q;
    logic [DIV_W-1:0]  divisor_q;
    int_status_t       int_status_q;
    int_status_t       int_enable_q;
    int_status_t       int_clr;
    int_status_t       int_set;
    logic              wr_en;
    logic              cmd_wr_ok;
    logic [DATA_W-1:0] rdata;

    // Zero wait states, writes land at the end of the access phase
    assign wr_en     = psel_i && penable_i && pwrite_i;
    assign cmd_wr_ok = wr_en && (paddr_i == COMMAND) && !cmd_busy_i;
    assign pready_o  = 1'b1;
    assign pslverr_o = wr_en && (paddr_i == COMMAND) && cmd_busy_i;

    // Write 1 to clear, a new completion wins over the clear
    assign int_clr = (wr_en && paddr_i == INT_STATUS) ?
                     int_status_t'(pwdata_i[$bits(int_status_t)-1:0]) : '0;
    assign int_set = cmd_done_i ? cmd_status_i : '0;

    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            argument_q   <= '0;
            cmd_q        <= '0;
            response_q   <= '0;
            divisor_q    <= DIV_W'(1);
            int_status_q <= '0;
            int_enable_q <= '0;
            cmd_start_o  <= 1'b0;
            interrupt_o  <= 1'b0;
        end else begin
            cmd_start_o  <= cmd_wr_ok;
            int_status_q <= (int_status_q & ~int_clr) | int_set;
            interrupt_o  <= |(int_status_q & int_enable_q);
            if (cmd_done_i) begin
                response_q <= cmd_resp_arg_i;
            end
            if (wr_en) begin
                case (reg_addr_e'(paddr_i))
                    ARGUMENT:   argument_q <= pwdata_i;
                    COMMAND: begin
                        if (!cmd_busy_i) begin
                            cmd_q <= cmd_reg_t'(pwdata_i & CMD_REG_MASK);
                        end
                    end
                    CLOCK_DIV:  divisor_q <= pwdata_i[DIV_W-1:0];
                    INT_ENABLE: begin
                        int_enable_q <= int_status_t'(pwdata_i[$bits(int_status_t)-1:0]);
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (reg_addr_e'(paddr_i))
            ARGUMENT:      rdata = argument_q;
            COMMAND:       rdata = cmd_q;
            RESPONSE:      rdata = response_q;
            CLOCK_DIV:     rdata = DATA_W'(divisor_q);
            INT_STATUS:    rdata = DATA_W'(int_status_q);
            INT_ENABLE:    rdata = DATA_W'(int_enable_q);
            // Bit 0 is command inhibit
            PRESENT_STATE: rdata = DATA_W'(cmd_busy_i);
            default:       rdata = '0;
        endcase
    end

    assign prdata_o = (psel_i && !pwrite_i) ? rdata : '0;

    // Argument is taken at start, the master holds its own copy
    assign cmd_req_o = '{
        index:       cmd_q.index,
        argument:    argument_q,
        resp_type:   cmd_q.resp_type,
        crc_check:   cmd_q.crc_check,
        index_check: cmd_q.index_check
    };

    assign divisor_o = divisor_q;

endmodule

//--- src/sd_clock_divider.sv
`timescale 1ns/1ps

module sd_clock_divider (
    input  logic                          pclk_i,
    input  logic                          reset_i,
    input  logic [sd_host_pkg::DIV_W-1:0] divisor_i,
    output logic                          sd_clk_o,
    output sd_host_pkg::sd_strobe_t       strobe_o
);

    import sd_host_pkg::*;

    logic [DIV_W-1:0] cnt_q;
    logic             wrap;

    // Also catches a divisor lowered below the running count
    assign wrap = (cnt_q >= divisor_i);

    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            cnt_q    <= '0;
            sd_clk_o <= 1'b0;
            strobe_o <= '0;
        end else begin
            cnt_q <= wrap ? '0 : cnt_q + 1'b1;
            if (wrap) begin
                sd_clk_o <= ~sd_clk_o;
            end
            // Strobes line up with the new clock level
            strobe_o.rise <= wrap && !sd_clk_o;
            strobe_o.fall <= wrap && sd_clk_o;
        end
    end

endmodule

//--- sd_cmd/sd_cmd_serial_host.sv
`timescale 1ns/1ps

module sd_cmd_serial_host #(
    parameter int CMD_TIMEOUT = 64
) (
    input  logic                    pclk_i,
    input  logic                    reset_i,
    input  sd_host_pkg::sd_strobe_t strobe_i,
    input  logic                    start_i,
    input  sd_host_pkg::cmd_frame_t frame_i,
    input  sd_host_pkg::resp_type_e resp_type_i,
    input  logic                    sd_cmd_i,
    output logic                    done_o,
    output sd_host_pkg::cmd_rsp_t   rsp_o,
    output logic                    sd_cmd_o,
    output logic                    sd_cmd_oe_o
);

    import sd_host_pkg::*;

    localparam int BODY_W = $bits(cmd_frame_t);
    localparam int TMO_W  = (CMD_TIMEOUT > 1) ? $clog2(CMD_TIMEOUT) : 1;

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_START,
        RECEIVE,
        DONE
    } state_e;

    state_e                 state_q;
    logic [5:0]             bit_cnt_q;
    logic [BODY_W-1:0]      tx_q;
    logic [CMD_FRAME_W-1:0] rx_q;
    logic [CRC7_W-1:0]      crc_q;
    logic [TMO_W-1:0]       tmo_cnt_q;
    logic                   want_rsp_q;
    logic                   timeout_q;
    logic                   received_q;

    function automatic logic [CRC7_W-1:0] crc7_next(input logic [CRC7_W-1:0] crc,
                                                    input logic din);
        logic fb;
        fb = crc[CRC7_W-1] ^ din;
        return {crc[CRC7_W-2:0], 1'b0} ^ (fb ? CRC7_POLY : '0);
    endfunction

    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            state_q     <= IDLE;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            bit_cnt_q   <= '0;
            crc_q       <= '0;
            tmo_cnt_q   <= '0;
            want_rsp_q  <= 1'b0;
            timeout_q   <= 1'b0;
            received_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        tx_q       <= frame_i;
                        crc_q      <= '0;
                        bit_cnt_q  <= '0;
                        tmo_cnt_q  <= '0;
                        want_rsp_q <= (resp_type_i != RESP_NONE);
                        timeout_q  <= 1'b0;
                        received_q <= 1'b0;
                        state_q    <= SEND;
                    end
                end
                // Line changes on the falling SD edge
                SEND: begin
                    if (strobe_i.fall) begin
                        bit_cnt_q   <= bit_cnt_q + 1'b1;
                        sd_cmd_oe_o <= 1'b1;
                        if (bit_cnt_q < BODY_W) begin
                            sd_cmd_o <= tx_q[BODY_W-1];
                            tx_q     <= tx_q << 1;
                            crc_q    <= crc7_next(crc_q, tx_q[BODY_W-1]);
                        end else if (bit_cnt_q < CMD_FRAME_W - 1) begin
                            // Seven shifts leave crc_q clear for the response
                            sd_cmd_o <= crc_q[CRC7_W-1];
                            crc_q    <= crc_q << 1;
                        end else if (bit_cnt_q == CMD_FRAME_W - 1) begin
                            sd_cmd_o <= 1'b1;
                        end else begin
                            sd_cmd_oe_o <= 1'b0;
                            sd_cmd_o    <= 1'b1;
                            bit_cnt_q   <= '0;
                            state_q     <= want_rsp_q ? WAIT_START : DONE;
                        end
                    end
                end
                WAIT_START: begin
                    if (strobe_i.rise) begin
                        if (!sd_cmd_i) begin
                            // Start bit sits in bit 0 and shifts up
                            rx_q      <= '0;
                            crc_q     <= crc7_next(crc_q, 1'b0);
                            bit_cnt_q <= 6'd1;
                            state_q   <= RECEIVE;
                        end else if (tmo_cnt_q == TMO_W'(CMD_TIMEOUT - 1)) begin
                            timeout_q <= 1'b1;
                            state_q   <= DONE;
                        end else begin
                            tmo_cnt_q <= tmo_cnt_q + 1'b1;
                        end
                    end
                end
                RECEIVE: begin
                    if (strobe_i.rise) begin
                        rx_q      <= {rx_q[CMD_FRAME_W-2:0], sd_cmd_i};
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q < BODY_W) begin
                            crc_q <= crc7_next(crc_q, sd_cmd_i);
                        end
                        if (bit_cnt_q == CMD_FRAME_W - 1) begin
                            received_q <= 1'b1;
                            state_q    <= DONE;
                        end
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign done_o = (state_q == DONE);

    // Frame fields below the start and direction bits
    assign rsp_o = '{
        index:    rx_q[CMD_FRAME_W-3 -: CMD_INDEX_W],
        argument: rx_q[CMD_FRAME_W-3-CMD_INDEX_W -: DATA_W],
        crc_ok:   (rx_q[CRC7_W:1] == crc_q),
        timeout:  timeout_q,
        received: received_q
    };

endmodule

//--- sd_cmd/sd_cmd_master.sv
`timescale 1ns/1ps

module sd_cmd_master #(
    parameter int CMD_TIMEOUT = 64
) (
    input  logic                           pclk_i,
    input  logic                           reset_i,
    input  logic                           start_i,
    input  sd_host_pkg::cmd_req_t          req_i,
    input  logic                           sd_cmd_i,
    input  sd_host_pkg::sd_strobe_t        strobe_i,
    output logic                           busy_o,
    output logic                           done_o,
    output sd_host_pkg::int_status_t       status_o,
    output logic [sd_host_pkg::DATA_W-1:0] resp_arg_o,
    output logic                           sd_cmd_o,
    output logic                           sd_cmd_oe_o
);

    import sd_host_pkg::*;

    cmd_req_t   req_q;
    logic       busy_q;
    logic       host_start_q;
    cmd_frame_t frame;
    logic       host_done;
    cmd_rsp_t   host_rsp;

    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            host_start_q <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            host_start_q <= start_i;
            done_o       <= host_done;
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge pclk_i) begin
        if (start_i) begin
            req_q <= req_i;
        end
        if (host_done) begin
            status_o.cmd_complete  <= 1'b1;
            status_o.cmd_timeout   <= host_rsp.timeout;
            status_o.cmd_crc_err   <= req_q.crc_check && host_rsp.received &&
                                      !host_rsp.crc_ok;
            status_o.cmd_index_err <= req_q.index_check && host_rsp.received &&
                                      (host_rsp.index != req_q.index);
            resp_arg_o <= host_rsp.received ? host_rsp.argument : '0;
        end
    end

    // Inhibit rises with the start pulse and drops after the done cycle
    assign busy_o = busy_q || start_i;

    assign frame = '{
        prefix:   FRAME_PREFIX_HOST,
        index:    req_q.index,
        argument: req_q.argument
    };

    sd_cmd_serial_host #(
        .CMD_TIMEOUT (CMD_TIMEOUT)
    ) i_serial_host (
        .pclk_i      (pclk_i),
        .reset_i     (reset_i),
        .strobe_i    (strobe_i),
        .start_i     (host_start_q),
        .frame_i     (frame),
        .resp_type_i (req_q.resp_type),
        .sd_cmd_i    (sd_cmd_i),
        .done_o      (host_done),
        .rsp_o       (host_rsp),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

endmodule

//--- src/sd_host_top.sv
`timescale 1ns/1ps

module sd_host_top #(
    parameter int CMD_TIMEOUT = 64
) (
    input  logic                               pclk_i,
    input  logic                               reset_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [sd_host_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [sd_host_pkg::DATA_W-1:0]     pwdata_i,
    output logic [sd_host_pkg::DATA_W-1:0]     prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    output logic                               sd_clk_o,
    output logic                               sd_cmd_o,
    output logic                               sd_cmd_oe_o,
    input  logic                               sd_cmd_i,
    output logic                               interrupt_o
);

    import sd_host_pkg::*;

    logic [DIV_W-1:0]  divisor;
    sd_strobe_t        strobe;
    cmd_req_t          cmd_req;
    logic              cmd_start;
    logic              cmd_busy;
    logic              cmd_done;
    int_status_t       cmd_status;
    logic [DATA_W-1:0] cmd_resp_arg;

    sd_regs i_regs (
        .pclk_i         (pclk_i),
        .reset_i        (reset_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .cmd_busy_i     (cmd_busy),
        .cmd_done_i     (cmd_done),
        .cmd_status_i   (cmd_status),
        .cmd_resp_arg_i (cmd_resp_arg),
        .cmd_req_o      (cmd_req),
        .cmd_start_o    (cmd_start),
        .divisor_o      (divisor),
        .interrupt_o    (interrupt_o)
    );

    sd_clock_divider i_clk_div (
        .pclk_i    (pclk_i),
        .reset_i   (reset_i),
        .divisor_i (divisor),
        .sd_clk_o  (sd_clk_o),
        .strobe_o  (strobe)
    );

    sd_cmd_master #(
        .CMD_TIMEOUT (CMD_TIMEOUT)
    ) i_cmd_master (
        .pclk_i      (pclk_i),
        .reset_i     (reset_i),
        .start_i     (cmd_start),
        .req_i       (cmd_req),
        .sd_cmd_i    (sd_cmd_i),
        .strobe_i    (strobe),
        .busy_o      (cmd_busy),
        .done_o      (cmd_done),
        .status_o    (cmd_status),
        .resp_arg_o  (cmd_resp_arg),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

endmodule

//--- tb/sd_card_stub.sv
`timescale 1ns/1ps

module sd_card_stub (
    input  logic        sd_clk_i,
    input  logic        cmd_oe_i,
    input  logic        cmd_i,
    output logic        cmd_o,
    input  logic        silent_i,
    input  logic [47:0] rsp_frame_i,
    output logic [47:0] frame_o,
    output int          frame_cnt_o
);

    logic [47:0] shift;
    int          nbits;

    initial begin
        cmd_o       = 1'b1;
        frame_o     = '0;
        frame_cnt_o = 0;
        shift       = '0;
        nbits       = 0;
    end

    // Host frame is sampled on rising SD edges
    always begin
        @(posedge sd_clk_i);
        if (cmd_oe_i) begin
            shift = {shift[46:0], cmd_i};
            nbits = nbits + 1;
            if (nbits == 48) begin
                frame_o     = shift;
                frame_cnt_o = frame_cnt_o + 1;
                nbits       = 0;
                if (!silent_i) begin
                    repeat (2) @(posedge sd_clk_i);
                    // Response bits change on falling SD edges
                    for (int i = 47; i >= 0; i--) begin
                        @(negedge sd_clk_i);
                        cmd_o = rsp_frame_i[i];
                    end
                    @(negedge sd_clk_i);
                    cmd_o = 1'b1;
                end
            end
        end
    end

endmodule

//--- tb/tb_sd_host.sv
`timescale 1ns/1ps

module tb_sd_host;

    import sd_host_pkg::*;

    localparam int CARD_OK        = 0;
    localparam int CARD_BAD_CRC   = 1;
    localparam int CARD_BAD_INDEX = 2;
    localparam int CARD_SILENT    = 3;
    localparam int NUM_ENTRIES    = 8;

    typedef struct {
        logic [5:0]  index;
        logic [31:0] argument;
        logic [1:0]  resp_type;
        logic        crc_check;
        logic        index_check;
        int          card;
        logic [31:0] card_arg;
        logic [3:0]  exp_status;
        logic [31:0] exp_resp;
    } entry_t;

    logic        pclk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sd_clk;
    logic        sd_cmd;
    logic        sd_cmd_oe;
    logic        card_cmd;
    logic        irq;
    logic        silent;
    logic [47:0] rsp_frame;
    logic [47:0] card_frame;
    int          frame_cnt;
    logic [31:0] lcg_state;
    int          error_count;
    entry_t      table_q[NUM_ENTRIES];

    sd_host_top #(
        .CMD_TIMEOUT (16)
    ) i_dut (
        .pclk_i      (pclk),
        .reset_i     (reset),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (card_cmd),
        .interrupt_o (irq)
    );

    sd_card_stub i_card (
        .sd_clk_i    (sd_clk),
        .cmd_oe_i    (sd_cmd_oe),
        .cmd_i       (sd_cmd),
        .cmd_o       (card_cmd),
        .silent_i    (silent),
        .rsp_frame_i (rsp_frame),
        .frame_o     (card_frame),
        .frame_cnt_o (frame_cnt)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // x^7 + x^3 + 1, MSB first, zero start
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge pclk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge pclk);
        penable = 1'b1;
        #2;
        err = pslverr;
        check_value("pready_o", pready, 1);
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge pclk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge pclk);
        penable = 1'b1;
        #2;
        data = prdata;
        check_value("pready_o", pready, 1);
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_cmd_idle();
        logic [31:0] state;
        int          polls;
        polls = 0;
        state = 32'h1;
        while (state[0]) begin
            apb_read(PRESENT_STATE, state);
            polls++;
            if (polls > 500) begin
                stop_on_timeout("command inhibit to clear");
            end
        end
    endtask

    task automatic add_entry(input int n, input logic [5:0] idx, input logic [31:0] arg,
                             input logic [1:0] rtype, input logic cchk, input logic ichk,
                             input int card, input logic [3:0] exp_status);
        table_q[n].index       = idx;
        table_q[n].argument    = arg;
        table_q[n].resp_type   = rtype;
        table_q[n].crc_check   = cchk;
        table_q[n].index_check = ichk;
        table_q[n].card        = card;
        table_q[n].card_arg    = lcg_next();
        table_q[n].exp_status  = exp_status;
        table_q[n].exp_resp    = (card == CARD_SILENT || rtype == 2'd0) ?
                                 32'h0 : table_q[n].card_arg;
    endtask

    task automatic run_entry(input entry_t e);
        logic [39:0] body;
        logic [6:0]  crc;
        logic [31:0] rd;
        logic        err;
        int          cnt_before;
        body = {2'b00, (e.card == CARD_BAD_INDEX) ? e.index + 6'd1 : e.index, e.card_arg};
        crc  = crc7(body);
        if (e.card == CARD_BAD_CRC) begin
            crc = ~crc;
        end
        rsp_frame  = {body, crc, 1'b1};
        silent     = (e.card == CARD_SILENT);
        cnt_before = frame_cnt;
        apb_write(ARGUMENT, e.argument, err);
        apb_write(COMMAND, {18'h0, e.index, 3'b000, e.index_check, e.crc_check, 1'b0,
                            e.resp_type}, err);
        check_value("pslverr_o", err, 0);
        wait_cmd_idle();
        check_value("frame count", frame_cnt, cnt_before + 1);
        body = {2'b01, e.index, e.argument};
        check_value("command frame", card_frame, {body, crc7(body), 1'b1});
        apb_read(INT_STATUS, rd);
        check_value("INT_STATUS", rd, e.exp_status);
        apb_read(RESPONSE, rd);
        check_value("RESPONSE", rd, e.exp_resp);
        // Masks that miss every set bit, hit only the error bits, hit completion
        apb_write(INT_ENABLE, {28'h0, ~e.exp_status}, err);
        @(negedge pclk);
        check_value("interrupt_o", irq, 0);
        apb_write(INT_ENABLE, 32'h0000_000e, err);
        @(negedge pclk);
        check_value("interrupt_o", irq, e.exp_status[3:1] != 3'b000);
        apb_write(INT_ENABLE, 32'h0000_0001, err);
        @(negedge pclk);
        check_value("interrupt_o", irq, 1);
        apb_write(INT_STATUS, 32'hf, err);
        @(negedge pclk);
        apb_read(INT_STATUS, rd);
        check_value("INT_STATUS after clear", rd, 0);
        check_value("interrupt_o after clear", irq, 0);
        apb_write(INT_ENABLE, 32'h0, err);
    endtask

    task automatic measure_period(input int div);
        logic err;
        logic prev;
        int   cnt;
        int   rises;
        int   guard;
        apb_write(CLOCK_DIV, div, err);
        prev  = sd_clk;
        cnt   = 0;
        rises = 0;
        guard = 0;
        while (rises < 3) begin
            @(negedge pclk);
            cnt++;
            guard++;
            if (guard > 200) begin
                stop_on_timeout("sd_clk_o rising edges");
            end
            if (sd_clk && !prev) begin
                if (rises >= 1) begin
                    check_value("sd_clk_o period", cnt, 2 * (div + 1));
                end
                rises++;
                cnt = 0;
            end
            prev = sd_clk;
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        int          cnt_before;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        silent      = 1'b1;
        rsp_frame   = '1;
        error_count = 0;
        lcg_state   = 32'hd60e_19d6;
        repeat (4) @(posedge pclk);
        @(negedge pclk);
        reset = 1'b0;

        // Reset values, unmapped offset included
        for (int a = 0; a <= 8'h1c; a += 4) begin
            apb_read(a[7:0], rd);
            check_value($sformatf("register 0x%02h", a), rd, (a == CLOCK_DIV) ? 1 : 0);
        end
        check_value("interrupt_o", irq, 0);
        check_value("sd_cmd_oe_o", sd_cmd_oe, 0);
        check_value("sd_cmd_o", sd_cmd, 1);

        apb_write(ARGUMENT, 32'ha5a5_5a5a, err);
        apb_read(ARGUMENT, rd);
        check_value("ARGUMENT", rd, 32'ha5a5_5a5a);
        apb_write(CLOCK_DIV, 32'h0000_0003, err);
        apb_read(CLOCK_DIV, rd);
        check_value("CLOCK_DIV", rd, 3);
        apb_write(CLOCK_DIV, 32'h0000_0001, err);
        apb_write(INT_ENABLE, 32'h0000_000f, err);
        apb_read(INT_ENABLE, rd);
        check_value("INT_ENABLE", rd, 32'hf);
        apb_write(INT_ENABLE, 32'h0, err);

        add_entry(0, 6'd0,  32'h0000_0000, 2'd0, 1'b0, 1'b0, CARD_SILENT,    4'b0001);
        add_entry(1, 6'd17, 32'h1234_5678, 2'd2, 1'b1, 1'b1, CARD_OK,        4'b0001);
        add_entry(2, 6'd8,  32'h0000_01aa, 2'd2, 1'b1, 1'b0, CARD_BAD_CRC,   4'b0101);
        add_entry(3, 6'd41, 32'hdead_beef, 2'd2, 1'b0, 1'b0, CARD_BAD_CRC,   4'b0001);
        add_entry(4, 6'd55, 32'h0bad_f00d, 2'd2, 1'b0, 1'b1, CARD_BAD_INDEX, 4'b1001);
        add_entry(5, 6'd13, 32'h8000_0001, 2'd3, 1'b0, 1'b0, CARD_BAD_INDEX, 4'b0001);
        add_entry(6, 6'd63, 32'hcafe_0123, 2'd1, 1'b1, 1'b1, CARD_BAD_INDEX, 4'b1001);
        add_entry(7, 6'd2,  32'hffff_ffff, 2'd2, 1'b1, 1'b1, CARD_SILENT,    4'b0011);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(table_q[i]);
        end

        // Second COMMAND write during inhibit
        silent     = 1'b1;
        cnt_before = frame_cnt;
        apb_write(COMMAND, 32'h0000_0502, err);
        check_value("pslverr_o first write", err, 0);
        apb_write(COMMAND, 32'h0000_0602, err);
        check_value("pslverr_o during inhibit", err, 1);
        wait_cmd_idle();
        check_value("frame count after inhibit", frame_cnt, cnt_before + 1);
        apb_read(COMMAND, rd);
        check_value("COMMAND after inhibited write", rd, 32'h0000_0502);
        apb_write(INT_STATUS, 32'hf, err);

        measure_period(1);
        measure_period(3);

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

//--- sd_host.f
common/sd_host_pkg.sv
src/sd_regs.sv
src/sd_clock_divider.sv
sd_cmd/sd_cmd_serial_host.sv
sd_cmd/sd_cmd_master.sv
src/sd_host_top.sv
tb/sd_card_stub.sv
tb/tb_sd_host.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_sd_host
FILELIST   ?= sd_host.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing
PASS_MSG   ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
